//--- cpu_pkg.sv
package cpu_pkg;

	typedef logic [63:0] addr_t;
	typedef logic [63:0] data_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [1:0] resp_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b // lui
	} alu_op_e;

	localparam logic [6:0] op_imm = 7'h13;
	localparam logic [6:0] op_reg = 7'h33;
	localparam logic [6:0] op_lui = 7'h37;
	localparam logic [6:0] op_trap = 7'h6b;

	typedef struct packed {
		logic valid;
		addr_t pc;
		inst_t inst;
	} fetch_t;

	typedef struct packed {
		alu_op_e alu_op;
		logic use_imm;
		logic wen;
		logic trap;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
	} ctrl_t;

	typedef struct packed {
		logic valid;
		addr_t pc;
		inst_t inst;
		ctrl_t ctrl;
		data_t src_a;
		data_t src_b;
	} issue_t;

	typedef struct packed {
		logic valid;
		addr_t pc;
		inst_t inst;
		logic wen;
		reg_idx_t rdest;
		data_t wdata;
		logic trap;
	} commit_t;

endpackage

//--- fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit #(
	parameter cpu_pkg::addr_t reset_pc = 64'h8000_0000
) (
	input logic clock,
	input logic reset,
	output cpu_pkg::addr_t araddr,
	output logic arvalid,
	input logic arready,
	input cpu_pkg::inst_t rdata,
	input logic rvalid,
	output logic rready,
	input logic halt,
	output cpu_pkg::fetch_t fetch
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {
		send_addr,
		wait_data,
		halted
	} fetch_state_e;

	fetch_state_e state;
	addr_t pc;
	logic running; // low until the first edge out of reset

	assign araddr = pc;
	// halt can only be high in the first send_addr cycle, so arvalid never drops early
	assign arvalid = running && (state == send_addr) && !halt;
	assign rready = (state != send_addr); // halted drains stray data

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= send_addr;
			pc <= reset_pc;
			running <= 1'b0;
		end else begin
			running <= 1'b1;
			unique case (state)
				send_addr: begin
					if (halt) begin
						state <= halted;
					end else if (arvalid && arready) begin
						state <= wait_data;
					end
				end
				wait_data: begin
					if (rvalid) begin // rready is high here
						state <= send_addr;
						pc <= pc + 64'd4;
					end
				end
				default: begin
					state <= halted;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		fetch.pc <= pc;
		fetch.inst <= rdata; // rresp ignored
		if (reset) begin
			fetch.valid <= 1'b0;
		end else begin
			fetch.valid <= (state == wait_data) && rvalid;
		end
	end

endmodule

//--- decoder.sv
`timescale 1ns/100ps

module decoder (
	input cpu_pkg::inst_t inst,
	output cpu_pkg::ctrl_t ctrl,
	output cpu_pkg::data_t imm
);
	import cpu_pkg::*;

	logic [2:0] funct3;
	logic [6:0] funct7;
	logic known;

	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = alu_add;
		ctrl.rs1 = inst[19:15];
		ctrl.rs2 = inst[24:20];
		ctrl.rd = inst[11:7];
		imm = '0;
		known = 1'b0;
		case (inst[6:0])
			op_imm: begin
				imm = {{52{inst[31]}}, inst[31:20]};
				ctrl.use_imm = 1'b1;
				known = 1'b1;
				case (funct3)
					3'b000: ctrl.alu_op = alu_add;
					3'b100: ctrl.alu_op = alu_xor;
					3'b110: ctrl.alu_op = alu_or;
					3'b111: ctrl.alu_op = alu_and;
					default: known = 1'b0;
				endcase
			end
			op_reg: begin
				known = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: ctrl.alu_op = alu_add;
					10'b0100000_000: ctrl.alu_op = alu_sub;
					10'b0000000_100: ctrl.alu_op = alu_xor;
					10'b0000000_110: ctrl.alu_op = alu_or;
					10'b0000000_111: ctrl.alu_op = alu_and;
					default: known = 1'b0;
				endcase
			end
			op_lui: begin
				imm = {{32{inst[31]}}, inst[31:12], 12'h000};
				ctrl.use_imm = 1'b1;
				ctrl.alu_op = alu_pass_b;
				ctrl.rs1 = '0;
				known = 1'b1;
			end
			op_trap: begin
				ctrl.trap = 1'b1;
				ctrl.rs1 = 5'd10; // a0 holds the trap code
				ctrl.rs2 = '0;
				known = 1'b1;
			end
			default: known = 1'b0;
		endcase
		ctrl.wen = known && !ctrl.trap && (ctrl.rd != '0);
	end

endmodule

//--- reg_file.sv
`timescale 1ns/100ps

module reg_file (
	input logic clock,
	input logic reset,
	input cpu_pkg::reg_idx_t raddr_a,
	input cpu_pkg::reg_idx_t raddr_b,
	output cpu_pkg::data_t rdata_a,
	output cpu_pkg::data_t rdata_b,
	input logic wen,
	input cpu_pkg::reg_idx_t waddr,
	input cpu_pkg::data_t wdata
);
	import cpu_pkg::*;

	data_t regs [32];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 hardwired
	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

//--- decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
	input logic clock,
	input logic reset,
	input cpu_pkg::fetch_t fetch,
	input cpu_pkg::commit_t wb,
	input cpu_pkg::reg_idx_t ex_rd,
	input logic ex_wen,
	input cpu_pkg::data_t ex_result,
	output logic halt,
	output cpu_pkg::issue_t issue
);
	import cpu_pkg::*;

	ctrl_t ctrl;
	data_t imm;
	data_t rf_a;
	data_t rf_b;
	data_t fwd_a;
	data_t fwd_b;
	logic wb_wen;

	// youngest producer wins
	function automatic data_t forward(reg_idx_t idx, data_t rf_val);
		data_t val;
		if (ex_wen && (ex_rd == idx)) begin
			val = ex_result;
		end else if (wb_wen && (wb.rdest == idx)) begin
			val = wb.wdata;
		end else begin
			val = rf_val;
		end
		return val;
	endfunction

	decoder decoder_i (
		.inst(fetch.inst),
		.ctrl(ctrl),
		.imm(imm)
	);

	assign wb_wen = wb.valid && wb.wen;

	reg_file reg_file_i (
		.clock(clock),
		.reset(reset),
		.raddr_a(ctrl.rs1),
		.raddr_b(ctrl.rs2),
		.rdata_a(rf_a),
		.rdata_b(rf_b),
		.wen(wb_wen),
		.waddr(wb.rdest),
		.wdata(wb.wdata)
	);

	always_comb begin
		fwd_a = forward(ctrl.rs1, rf_a);
		fwd_b = forward(ctrl.rs2, rf_b);
	end

	assign halt = fetch.valid && ctrl.trap;

	always_ff @(posedge clock) begin
		issue.pc <= fetch.pc;
		issue.inst <= fetch.inst;
		issue.ctrl <= ctrl;
		issue.src_a <= fwd_a;
		issue.src_b <= ctrl.use_imm ? imm : fwd_b;
		if (reset) begin
			issue.valid <= 1'b0;
		end else begin
			issue.valid <= fetch.valid;
		end
	end

endmodule

//--- execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
	input logic clock,
	input logic reset,
	input cpu_pkg::issue_t issue,
	output cpu_pkg::reg_idx_t ex_rd,
	output logic ex_wen,
	output cpu_pkg::data_t ex_result,
	output cpu_pkg::commit_t commit
);
	import cpu_pkg::*;

	data_t result;

	always_comb begin
		unique case (issue.ctrl.alu_op)
			alu_sub: result = issue.src_a - issue.src_b;
			alu_and: result = issue.src_a & issue.src_b;
			alu_or: result = issue.src_a | issue.src_b;
			alu_xor: result = issue.src_a ^ issue.src_b;
			alu_pass_b: result = issue.src_b;
			default: result = issue.src_a + issue.src_b;
		endcase
	end

	// bypass path back to decode
	assign ex_rd = issue.ctrl.rd;
	assign ex_wen = issue.valid && issue.ctrl.wen;
	assign ex_result = result;

	always_ff @(posedge clock) begin
		commit.pc <= issue.pc;
		commit.inst <= issue.inst;
		commit.wen <= issue.ctrl.wen;
		commit.rdest <= issue.ctrl.rd;
		commit.wdata <= issue.ctrl.trap ? issue.src_a : result; // trap reports a0
		commit.trap <= issue.ctrl.trap;
		if (reset) begin
			commit.valid <= 1'b0;
		end else begin
			commit.valid <= issue.valid;
		end
	end

endmodule

//--- cpu_top.sv
`timescale 1ns/100ps

module cpu_top #(
	parameter cpu_pkg::addr_t reset_pc = 64'h8000_0000
) (
	input logic clock,
	input logic reset,
	output cpu_pkg::addr_t araddr,
	output logic arvalid,
	input logic arready,
	input cpu_pkg::inst_t rdata,
	input cpu_pkg::resp_t rresp, // error responses retire like okay
	input logic rvalid,
	output logic rready,
	output cpu_pkg::commit_t commit,
	output logic trap,
	output logic [7:0] trap_code
);
	import cpu_pkg::*;

	fetch_t fetch;
	issue_t issue;
	logic halt;
	reg_idx_t ex_rd;
	logic ex_wen;
	data_t ex_result;
	logic trap_q;
	logic [7:0] code_q;
	logic trap_commit;

	fetch_unit #(.reset_pc(reset_pc)) fetch_unit_i (
		.clock(clock),
		.reset(reset),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rready(rready),
		.halt(halt),
		.fetch(fetch)
	);

	decode_stage decode_stage_i (
		.clock(clock),
		.reset(reset),
		.fetch(fetch),
		.wb(commit),
		.ex_rd(ex_rd),
		.ex_wen(ex_wen),
		.ex_result(ex_result),
		.halt(halt),
		.issue(issue)
	);

	execute_stage execute_stage_i (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.ex_rd(ex_rd),
		.ex_wen(ex_wen),
		.ex_result(ex_result),
		.commit(commit)
	);

	assign trap_commit = commit.valid && commit.trap;
	assign trap = trap_q || trap_commit; // up in the commit cycle itself
	assign trap_code = trap_commit ? commit.wdata[7:0] : code_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			trap_q <= 1'b0;
			code_q <= '0;
		end else if (trap_commit) begin
			trap_q <= 1'b1;
			code_q <= commit.wdata[7:0];
		end
	end

endmodule

//--- cpu_asserts.sv
`timescale 1ns/100ps

module cpu_asserts (
	input logic clock,
	input logic reset,
	input cpu_pkg::addr_t araddr,
	input logic arvalid,
	input logic arready,
	input logic rvalid,
	input logic rready,
	input cpu_pkg::commit_t commit,
	input logic trap
);
	int unsigned error_count = 0;

	idle_after_reset: assert property (@(posedge clock) reset |=> !arvalid && !commit.valid && !trap)
		else begin
			$error("bus or commit port active right after a reset cycle");
			error_count++;
		end

	// request held until accepted
	ar_stable: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			$error("arvalid dropped or araddr changed before arready");
			error_count++;
		end

	r_to_commit: assert property (@(posedge clock) disable iff (reset)
		rvalid && rready && !trap |-> ##3 commit.valid)
		else begin
			$error("no commit three cycles after the read data transfer");
			error_count++;
		end

	commit_from_r: assert property (@(posedge clock) disable iff (reset)
		commit.valid |-> $past(rvalid && rready, 3))
		else begin
			$error("commit without a read data transfer three cycles earlier");
			error_count++;
		end

	trap_sticky: assert property (@(posedge clock) disable iff (reset)
		trap |=> trap && !arvalid && !commit.valid)
		else begin
			$error("activity or trap drop after the trap");
			error_count++;
		end

endmodule

//--- tb_cpu_top.sv
`timescale 1ns/100ps

module tb_cpu_top;
	import cpu_pkg::*;

	localparam addr_t reset_pc = 64'h8000_0000;
	localparam int prog_len = 19;
	localparam int quiet_cycles = 20;
	localparam int cycle_limit = 4 * (5 + 8 * prog_len + quiet_cycles); // 8 = slowest fetch

	logic clock;
	logic reset;
	addr_t araddr;
	logic arvalid;
	logic arready = 1'b0;
	inst_t rdata = '0;
	resp_t rresp = '0;
	logic rvalid = 1'b0;
	logic rready;
	commit_t commit;
	logic trap;
	logic [7:0] trap_code;

	inst_t prog [prog_len] = '{
		32'h0050_0093, // addi x1, x0, 5
		32'h0070_8113, // addi x2, x1, 7
		32'h0020_81b3, // add x3, x1, x2
		32'h4011_8233, // sub x4, x3, x1
		32'h1234_52b7, // lui x5, 0x12345
		32'hfff2_c313, // xori x6, x5, -1
		32'h0043_63b3, // or x7, x6, x4
		32'h0053_f433, // and x8, x7, x5
		32'h0630_8013, // addi x0, x1, 99
		32'h0010_04b3, // add x9, x0, x1
		32'h8000_05b7, // lui x11, 0x80000
		32'h7ff5_e613, // ori x12, x11, 0x7ff
		32'h0096_46b3, // xor x13, x12, x9
		32'hff06_f713, // andi x14, x13, -16
		32'h40e0_07b3, // sub x15, x0, x14
		32'h0000_0000, // unknown, no write
		32'h00f7_8833, // add x16, x15, x15
		32'h0358_0513, // addi x10, x16, 0x35
		32'h0000_006b  // trap
	};

	logic [31:0] lfsr_state = 32'h1255;
	logic data_phase = 1'b0;
	logic drawn = 1'b0;
	int unsigned wait_cnt = 0;
	int unsigned resp_bit;
	logic [4:0] mem_idx = '0;
	logic [4:0] pos;
	addr_t next_addr = reset_pc;
	data_t model_regs [32] = '{default: '0};
	addr_t exp_pc = reset_pc;
	logic exp_wen;
	data_t exp_val;
	logic trap_done = 1'b0;
	int cycles = 0;
	int quiet = 0;

	cpu_top dut_i (.*);

	bind cpu_top cpu_asserts asserts_i (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(negedge clock);
		reset <= 1'b0;
	end

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int unsigned v);
		v = 0;
		for (int k = 0; k < n; k++) begin
			v = (v << 1) | 32'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic stop_with_failure();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(string test, logic [63:0] expected, logic [63:0] actual);
		$display("[ERROR] %s: expected %h, actual %h", test, expected, actual);
		stop_with_failure();
	endtask

	task automatic report_problem(string what);
		$display("%s", what);
		stop_with_failure();
	endtask

	// ISA semantics of the kept instructions
	task automatic model_step(input inst_t i, output logic wen, output data_t val);
		data_t a;
		data_t b;
		data_t imm;
		logic known;
		a = model_regs[i[19:15]];
		b = model_regs[i[24:20]];
		imm = {{52{i[31]}}, i[31:20]};
		known = 1'b1;
		val = '0;
		case (i[6:0])
			7'h13: case (i[14:12])
				3'd0: val = a + imm;
				3'd4: val = a ^ imm;
				3'd6: val = a | imm;
				3'd7: val = a & imm;
				default: known = 1'b0;
			endcase
			7'h33: case ({i[31:25], i[14:12]})
				10'h000: val = a + b;
				10'h100: val = a - b;
				10'h004: val = a ^ b;
				10'h006: val = a | b;
				10'h007: val = a & b;
				default: known = 1'b0;
			endcase
			7'h37: val = {{32{i[31]}}, i[31:12], 12'h000};
			default: known = 1'b0;
		endcase
		wen = known && (i[11:7] != 5'd0);
	endtask

	task automatic finish_run();
		if (dut_i.asserts_i.error_count == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			report_problem("a bound protocol assertion failed");
		end
	endtask

	// instruction memory, random ready and valid delays
	always @(negedge clock) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else if (!data_phase) begin
			rvalid <= 1'b0;
			arready <= 1'b0;
			if (arvalid) begin
				if (!drawn) begin
					take_bits(2, wait_cnt); // 0 to 3 cycles
					drawn = 1'b1;
				end
				if (wait_cnt == 0) begin
					assert (araddr == next_addr) else report_mismatch("araddr", next_addr, araddr);
					assert (araddr - reset_pc < 64'(4 * prog_len))
						else report_problem("fetch past the end of the program");
					mem_idx = 5'((araddr - reset_pc) >> 2);
					next_addr = next_addr + 64'd4;
					arready <= 1'b1;
					data_phase = 1'b1;
					drawn = 1'b0;
				end else begin
					wait_cnt--;
				end
			end
		end else begin
			arready <= 1'b0;
			if (!drawn) begin
				take_bits(2, wait_cnt);
				drawn = 1'b1;
			end
			if (wait_cnt == 0) begin
				take_bits(1, resp_bit);
				rdata <= prog[mem_idx];
				rresp <= resp_bit[0] ? 2'b10 : 2'b00; // slverr retires too
				rvalid <= 1'b1;
				data_phase = 1'b0;
				drawn = 1'b0;
			end else begin
				wait_cnt--;
			end
		end
	end

	// reference model, stepped per commit
	always @(negedge clock) begin
		cycles++;
		if (cycles > cycle_limit) begin
			report_problem("timeout, the trap was not reached in time");
		end
		if (!reset) begin
			assert (dut_i.asserts_i.error_count == 0)
				else report_problem("a bound protocol assertion failed");
			if (trap_done) begin
				assert (!commit.valid) else report_problem("commit after the trap");
				assert (!arvalid) else report_problem("fetch request after the trap");
				quiet++;
				if (quiet == quiet_cycles) finish_run();
			end else if (commit.valid) begin
				pos = 5'((exp_pc - reset_pc) >> 2);
				assert (commit.pc == exp_pc) else report_mismatch("commit pc", exp_pc, commit.pc);
				assert (commit.inst == prog[pos])
					else report_mismatch("commit inst", 64'(prog[pos]), 64'(commit.inst));
				if (commit.inst[6:0] == 7'h6b) begin
					assert (trap && commit.trap)
						else report_problem("trap flag not raised with the trap commit");
					assert (trap_code == model_regs[10][7:0])
						else report_mismatch("trap code", 64'(model_regs[10][7:0]), 64'(trap_code));
					trap_done = 1'b1;
				end else begin
					assert (!trap) else report_problem("trap flag raised before the trap");
					model_step(commit.inst, exp_wen, exp_val);
					assert (commit.wen == exp_wen)
						else report_mismatch("commit wen", 64'(exp_wen), 64'(commit.wen));
					if (exp_wen) begin
						assert (commit.rdest == commit.inst[11:7])
							else report_mismatch("commit rdest", 64'(commit.inst[11:7]),
								64'(commit.rdest));
						assert (commit.wdata == exp_val)
							else report_mismatch("commit wdata", exp_val, commit.wdata);
						model_regs[commit.inst[11:7]] = exp_val;
					end
				end
				exp_pc = exp_pc + 64'd4;
			end else begin
				assert (!trap) else report_problem("trap flag raised without a commit");
			end
		end
	end

endmodule

//--- cpu_top.f
cpu_pkg.sv
fetch_unit.sv
decoder.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
cpu_top.sv
cpu_asserts.sv
tb_cpu_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_cpu_top
FILELIST = cpu_top.f
OBJ_DIR = obj_dir
RUN_ARGS = +verilator+error+limit+100

SIM = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$($(SIM) $(RUN_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "^Test completed successfully$$"

clean:
	rm -rf $(OBJ_DIR)
